//--- rtl/rs_pkg.sv
package rs_pkg;

    // Datapath widths
    localparam int WORD_W     = 32;
    localparam int TAG_W      = 4;
    localparam int REG_ADDR_W = 5;

    // Operand or result value
    typedef logic [WORD_W-1:0] word_t;

    // Station tag, zero means the value is ready
    typedef logic [TAG_W-1:0] tag_t;

    // Architectural register number
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam int NUM_REGS = 32;

    // Bank sizes
    localparam int NUM_ADD = 3;
    localparam int NUM_MUL = 2;

    // Tag ranges must stay disjoint and nonzero
    localparam tag_t ADD_BASE_TAG = 4'd1;
    localparam tag_t MUL_BASE_TAG = 4'd4;

endpackage

//--- rtl/register_status.sv
module register_status #(
    parameter int NUM_REGS = rs_pkg::NUM_REGS
) (
    input  logic              clk,
    input  logic              reset,
    input  rs_pkg::reg_addr_t rs,
    input  rs_pkg::reg_addr_t rt,
    input  rs_pkg::reg_addr_t rd,
    input  logic              rename,
    input  rs_pkg::tag_t      rename_tag,
    input  logic              cdb_valid,
    input  rs_pkg::tag_t      cdb_tag,
    input  rs_pkg::word_t     cdb_data,
    output rs_pkg::tag_t      tag_j,
    output rs_pkg::tag_t      tag_k,
    output logic              reg_write_valid,
    output rs_pkg::reg_addr_t reg_write_addr,
    output rs_pkg::word_t     reg_write_data
);
    import rs_pkg::*;

    // Producer tag per architectural register
    tag_t      status [NUM_REGS];
    logic      hit;
    reg_addr_t hit_addr;

    assign tag_j = status[rs];
    assign tag_k = status[rt];

    // Highest matching register wins the write-back
    always_comb begin
        hit      = 1'b0;
        hit_addr = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (cdb_valid && cdb_tag != '0 && status[i] == cdb_tag) begin
                hit      = 1'b1;
                hit_addr = reg_addr_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                status[i] <= '0;
            end
            reg_write_valid <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (cdb_valid && cdb_tag != '0 && status[i] == cdb_tag) begin
                    status[i] <= '0;
                end
            end
            // Rename overrides a clear of the same register
            if (rename) begin
                status[rd] <= rename_tag;
            end
            reg_write_valid <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            reg_write_addr <= hit_addr;
            reg_write_data <= cdb_data;
        end
    end

endmodule

//--- rtl/station_bank.sv
module station_bank #(
    parameter int           NUM_ENTRIES = rs_pkg::NUM_ADD,
    parameter rs_pkg::tag_t BASE_TAG    = rs_pkg::ADD_BASE_TAG
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue,
    input  logic                   imminstr,
    input  logic                   op_flag,
    input  rs_pkg::tag_t           tag_j,
    input  rs_pkg::tag_t           tag_k,
    input  rs_pkg::word_t          read_data1,
    input  rs_pkg::word_t          read_data2,
    input  rs_pkg::word_t          ext_imm,
    input  logic                   cdb_valid,
    input  rs_pkg::tag_t           cdb_tag,
    input  rs_pkg::word_t          cdb_data,
    output logic [NUM_ENTRIES-1:0] busy,
    output rs_pkg::tag_t           alloc_tag,
    output logic [NUM_ENTRIES-1:0] start,
    output rs_pkg::word_t          src_a [NUM_ENTRIES],
    output rs_pkg::word_t          src_b [NUM_ENTRIES],
    output logic [NUM_ENTRIES-1:0] op
);
    import rs_pkg::*;

    logic [NUM_ENTRIES-1:0] fired;
    logic [NUM_ENTRIES-1:0] entry_op;
    word_t                  vj [NUM_ENTRIES];
    word_t                  vk [NUM_ENTRIES];
    tag_t                   qj [NUM_ENTRIES];
    tag_t                   qk [NUM_ENTRIES];

    int                     alloc_idx;
    logic [NUM_ENTRIES-1:0] take;
    logic [NUM_ENTRIES-1:0] ready;
    logic [NUM_ENTRIES-1:0] wake_j;
    logic [NUM_ENTRIES-1:0] wake_k;
    logic [NUM_ENTRIES-1:0] release_entry;

    logic  j_hit;
    logic  k_hit;
    word_t cap_vj;
    word_t cap_vk;
    tag_t  cap_qj;
    tag_t  cap_qk;

    // Lowest free entry
    always_comb begin
        alloc_idx = 0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_idx = i;
            end
        end
    end

    assign alloc_tag = BASE_TAG + tag_t'(alloc_idx);

    // Source already on the CDB this cycle is taken as data
    assign j_hit  = cdb_valid && tag_j != '0 && cdb_tag == tag_j;
    assign k_hit  = cdb_valid && tag_k != '0 && cdb_tag == tag_k;
    assign cap_vj = j_hit ? cdb_data : read_data1;
    assign cap_qj = j_hit ? '0 : tag_j;

    always_comb begin
        if (imminstr) begin
            cap_vk = ext_imm;
            cap_qk = '0;
        end else begin
            cap_vk = k_hit ? cdb_data : read_data2;
            cap_qk = k_hit ? '0 : tag_k;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            take[i]          = issue && (alloc_idx == i);
            ready[i]         = busy[i] && !fired[i] && qj[i] == '0 && qk[i] == '0;
            wake_j[i]        = cdb_valid && qj[i] != '0 && qj[i] == cdb_tag;
            wake_k[i]        = cdb_valid && qk[i] != '0 && qk[i] == cdb_tag;
            release_entry[i] = cdb_valid && cdb_tag == BASE_TAG + tag_t'(i);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= '0;
            fired <= '0;
            start <= '0;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                qj[i] <= '0;
                qk[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                start[i] <= ready[i];
                if (ready[i]) begin
                    fired[i] <= 1'b1;
                end
                if (wake_j[i]) begin
                    qj[i] <= '0;
                end
                if (wake_k[i]) begin
                    qk[i] <= '0;
                end
                if (release_entry[i]) begin
                    busy[i]  <= 1'b0;
                    fired[i] <= 1'b0;
                end
                // Allocation only ever lands on a free entry
                if (take[i]) begin
                    busy[i]  <= 1'b1;
                    fired[i] <= 1'b0;
                    qj[i]    <= cap_qj;
                    qk[i]    <= cap_qk;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (ready[i]) begin
                src_a[i] <= vj[i];
                src_b[i] <= vk[i];
                op[i]    <= entry_op[i];
            end
            if (wake_j[i]) begin
                vj[i] <= cdb_data;
            end
            if (wake_k[i]) begin
                vk[i] <= cdb_data;
            end
            if (take[i]) begin
                vj[i]       <= cap_vj;
                vk[i]       <= cap_vk;
                entry_op[i] <= op_flag;
            end
        end
    end

endmodule

//--- rtl/issue_control.sv
module issue_control #(
    parameter int NUM_ADD = rs_pkg::NUM_ADD,
    parameter int NUM_MUL = rs_pkg::NUM_MUL
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               add_en,
    input  logic               mul_en,
    input  rs_pkg::reg_addr_t  rs,
    input  rs_pkg::reg_addr_t  rt,
    input  rs_pkg::reg_addr_t  rd,
    input  logic [NUM_ADD-1:0] add_busy,
    input  logic [NUM_MUL-1:0] mul_busy,
    input  rs_pkg::tag_t       add_alloc_tag,
    input  rs_pkg::tag_t       mul_alloc_tag,
    output logic               add_issue,
    output logic               mul_issue,
    output logic               rename,
    output rs_pkg::tag_t       rename_tag,
    output logic               a_stall,
    output logic               done
);

    logic valid;
    logic add_full;
    logic mul_full;
    logic empty;
    logic was_busy;
    logic done_pend;

    // All-zero rs, rt and rd encodes a bubble
    assign valid    = (rs != '0) || (rt != '0) || (rd != '0);
    assign add_full = &add_busy;
    assign mul_full = &mul_busy;
    assign empty    = !(|add_busy) && !(|mul_busy);

    // Adder request takes priority over multiplier
    assign add_issue  = add_en && valid && !add_full;
    assign mul_issue  = !add_en && mul_en && valid && !mul_full;
    assign rename     = add_issue || mul_issue;
    assign rename_tag = add_issue ? add_alloc_tag : mul_alloc_tag;

    assign a_stall = (add_en && add_full) || (mul_en && mul_full);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            was_busy  <= 1'b0;
            done_pend <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (!empty) begin
                was_busy <= 1'b1;
            end
            done_pend <= was_busy && empty;
            // Sticky until reset
            if (done_pend) begin
                done <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/tomasulo_rs.sv
module tomasulo_rs #(
    parameter int           NUM_REGS     = rs_pkg::NUM_REGS,
    parameter int           NUM_ADD      = rs_pkg::NUM_ADD,
    parameter int           NUM_MUL      = rs_pkg::NUM_MUL,
    parameter rs_pkg::tag_t ADD_BASE_TAG = rs_pkg::ADD_BASE_TAG,
    parameter rs_pkg::tag_t MUL_BASE_TAG = rs_pkg::MUL_BASE_TAG
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               add_en,
    input  logic               mul_en,
    input  logic               imminstr,
    input  logic               op_flag,
    input  rs_pkg::reg_addr_t  rs,
    input  rs_pkg::reg_addr_t  rt,
    input  rs_pkg::reg_addr_t  rd,
    input  rs_pkg::word_t      ext_imm,
    input  rs_pkg::word_t      read_data1,
    input  rs_pkg::word_t      read_data2,
    input  logic               cdb_valid,
    input  rs_pkg::tag_t       cdb_tag,
    input  rs_pkg::word_t      cdb_data,
    output logic [NUM_ADD-1:0] add_start,
    output rs_pkg::word_t      add_src_a [NUM_ADD],
    output rs_pkg::word_t      add_src_b [NUM_ADD],
    output logic [NUM_ADD-1:0] add_op,
    output logic [NUM_MUL-1:0] mul_start,
    output rs_pkg::word_t      mul_src_a [NUM_MUL],
    output rs_pkg::word_t      mul_src_b [NUM_MUL],
    output logic [NUM_MUL-1:0] mul_op,
    output logic               a_stall,
    output logic               reg_write_valid,
    output rs_pkg::reg_addr_t  reg_write_addr,
    output rs_pkg::word_t      reg_write_data,
    output logic               done
);
    import rs_pkg::*;

    logic               add_issue;
    logic               mul_issue;
    logic               rename;
    tag_t               rename_tag;
    tag_t               tag_j;
    tag_t               tag_k;
    logic [NUM_ADD-1:0] add_busy;
    logic [NUM_MUL-1:0] mul_busy;
    tag_t               add_alloc_tag;
    tag_t               mul_alloc_tag;

    issue_control #(
        .NUM_ADD (NUM_ADD),
        .NUM_MUL (NUM_MUL)
    ) issue_ctl (
        .clk           (clk),
        .reset         (reset),
        .add_en        (add_en),
        .mul_en        (mul_en),
        .rs            (rs),
        .rt            (rt),
        .rd            (rd),
        .add_busy      (add_busy),
        .mul_busy      (mul_busy),
        .add_alloc_tag (add_alloc_tag),
        .mul_alloc_tag (mul_alloc_tag),
        .add_issue     (add_issue),
        .mul_issue     (mul_issue),
        .rename        (rename),
        .rename_tag    (rename_tag),
        .a_stall       (a_stall),
        .done          (done)
    );

    register_status #(
        .NUM_REGS (NUM_REGS)
    ) reg_stat (
        .clk             (clk),
        .reset           (reset),
        .rs              (rs),
        .rt              (rt),
        .rd              (rd),
        .rename          (rename),
        .rename_tag      (rename_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_data        (cdb_data),
        .tag_j           (tag_j),
        .tag_k           (tag_k),
        .reg_write_valid (reg_write_valid),
        .reg_write_addr  (reg_write_addr),
        .reg_write_data  (reg_write_data)
    );

    station_bank #(
        .NUM_ENTRIES (NUM_ADD),
        .BASE_TAG    (ADD_BASE_TAG)
    ) add_bank (
        .clk        (clk),
        .reset      (reset),
        .issue      (add_issue),
        .imminstr   (imminstr),
        .op_flag    (op_flag),
        .tag_j      (tag_j),
        .tag_k      (tag_k),
        .read_data1 (read_data1),
        .read_data2 (read_data2),
        .ext_imm    (ext_imm),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_data   (cdb_data),
        .busy       (add_busy),
        .alloc_tag  (add_alloc_tag),
        .start      (add_start),
        .src_a      (add_src_a),
        .src_b      (add_src_b),
        .op         (add_op)
    );

    station_bank #(
        .NUM_ENTRIES (NUM_MUL),
        .BASE_TAG    (MUL_BASE_TAG)
    ) mul_bank (
        .clk        (clk),
        .reset      (reset),
        .issue      (mul_issue),
        .imminstr   (imminstr),
        .op_flag    (op_flag),
        .tag_j      (tag_j),
        .tag_k      (tag_k),
        .read_data1 (read_data1),
        .read_data2 (read_data2),
        .ext_imm    (ext_imm),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_data   (cdb_data),
        .busy       (mul_busy),
        .alloc_tag  (mul_alloc_tag),
        .start      (mul_start),
        .src_a      (mul_src_a),
        .src_b      (mul_src_b),
        .op         (mul_op)
    );

endmodule

//--- testbench/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Architectural register values in program order
word_t ref_regs [NUM_REGS];

// Latest producer tag per register, zero when the value is committed
tag_t ref_status [NUM_REGS];

// Expected operands and result of one issued instruction
function automatic void predict(
    input  logic      is_mul,
    input  logic      op,
    input  logic      imm,
    input  reg_addr_t src1,
    input  reg_addr_t src2,
    input  reg_addr_t dst,
    input  word_t     imm_val,
    output word_t     a,
    output word_t     b,
    output word_t     r
);
    a = ref_regs[src1];
    b = imm ? imm_val : ref_regs[src2];
    if (is_mul) begin
        r = a * b;
    end else if (op) begin
        r = a + b;
    end else begin
        r = a - b;
    end
    ref_regs[dst] = r;
endfunction

// Highest register still owned by tag t, or -1
function automatic int latest_owner(input tag_t t);
    int idx;
    idx = -1;
    for (int i = 0; i < NUM_REGS; i++) begin
        if (ref_status[i] == t) begin
            idx = i;
        end
    end
    return idx;
endfunction

`endif

//--- testbench/tb_top.sv
module tb_top;
    import rs_pkg::*;

    // Slot per tag with index 0 unused
    localparam int NUM_TAGS = NUM_ADD + NUM_MUL + 1;

    logic               clk;
    logic               reset;
    logic               add_en;
    logic               mul_en;
    logic               imminstr;
    logic               op_flag;
    reg_addr_t          rs;
    reg_addr_t          rt;
    reg_addr_t          rd;
    word_t              ext_imm;
    word_t              read_data1;
    word_t              read_data2;
    logic               cdb_valid;
    tag_t               cdb_tag;
    word_t              cdb_data;
    logic [NUM_ADD-1:0] add_start;
    word_t              add_src_a [NUM_ADD];
    word_t              add_src_b [NUM_ADD];
    logic [NUM_ADD-1:0] add_op;
    logic [NUM_MUL-1:0] mul_start;
    word_t              mul_src_a [NUM_MUL];
    word_t              mul_src_b [NUM_MUL];
    logic [NUM_MUL-1:0] mul_op;
    logic               a_stall;
    logic               reg_write_valid;
    reg_addr_t          reg_write_addr;
    word_t              reg_write_data;
    logic               done;

    `include "tb_ref.svh"

    word_t  rf [NUM_REGS];
    word_t  init_vals [NUM_REGS];
    int     delay_tab [256];
    integer seed;
    int     errors = 0;
    int     flow_errors = 0;
    int     cyc = 0;
    int     dly_idx;
    logic   accepted;

    // Station model with one slot per tag
    logic   m_busy [NUM_TAGS];
    logic   m_started [NUM_TAGS];
    tag_t   m_wj [NUM_TAGS];
    tag_t   m_wk [NUM_TAGS];
    int     m_rdy [NUM_TAGS];
    word_t  exp_a [NUM_TAGS];
    word_t  exp_b [NUM_TAGS];
    word_t  exp_r [NUM_TAGS];
    logic   exp_op [NUM_TAGS];

    // Behavioral execution units
    logic   u_pend [NUM_TAGS];
    int     u_delay [NUM_TAGS];
    word_t  u_res [NUM_TAGS];

    logic      bc_v;
    tag_t      bc_t;
    word_t     bc_d;
    logic      wb_v;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      was_busy;
    int        empty_edge;

    tomasulo_rs dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic tag_t free_tag(input logic is_mul);
        tag_t found;
        tag_t base;
        int   n;
        base  = is_mul ? MUL_BASE_TAG : ADD_BASE_TAG;
        n     = is_mul ? NUM_MUL : NUM_ADD;
        found = '0;
        for (int i = n - 1; i >= 0; i--) begin
            if (!m_busy[base + tag_t'(i)]) begin
                found = base + tag_t'(i);
            end
        end
        return found;
    endfunction

    function automatic logic model_idle();
        logic idle;
        idle = 1'b1;
        for (int t = 1; t < NUM_TAGS; t++) begin
            if (m_busy[t]) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    function automatic void read_start(input int t, output logic s, output word_t a,
                                       output word_t b, output logic o);
        int i;
        if (t >= int'(MUL_BASE_TAG)) begin
            i = t - int'(MUL_BASE_TAG);
            s = mul_start[i];
            a = mul_src_a[i];
            b = mul_src_b[i];
            o = mul_op[i];
        end else begin
            i = t - int'(ADD_BASE_TAG);
            s = add_start[i];
            a = add_src_a[i];
            b = add_src_b[i];
            o = add_op[i];
        end
    endfunction

    // Register file read with the write-back in flight bypassed
    function automatic word_t rf_read(input reg_addr_t addr);
        if (reg_write_valid && reg_write_addr == addr) begin
            return reg_write_data;
        end
        return rf[addr];
    endfunction

    always @(posedge clk) begin
        int    owner;
        logic  is_mul_i;
        logic  take;
        logic  stall_exp;
        logic  exp_done;
        logic  waiting;
        logic  s;
        logic  so;
        logic  exp_s;
        word_t sa;
        word_t sb;
        word_t a;
        word_t b;
        word_t r;
        tag_t  wj;
        tag_t  wk;
        tag_t  slot;
        cyc++;
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i]         = init_vals[i];
                ref_regs[i]   = init_vals[i];
                ref_status[i] = '0;
            end
            for (int t = 0; t < NUM_TAGS; t++) begin
                m_busy[t] = 1'b0;
                u_pend[t] = 1'b0;
            end
            wb_v       = 1'b0;
            bc_v       = 1'b0;
            was_busy   = 1'b0;
            empty_edge = -1;
            accepted   = 1'b0;
            dly_idx    = 0;
        end else begin
            if (reg_write_valid !== wb_v) begin
                $display("Error: reg_write_valid expected %h got %h", wb_v, reg_write_valid);
                errors++;
            end else if (wb_v) begin
                if (reg_write_addr !== wb_addr) begin
                    $display("Error: reg_write_addr expected %h got %h", wb_addr, reg_write_addr);
                    errors++;
                end
                if (reg_write_data !== wb_data) begin
                    $display("Error: reg_write_data expected %h got %h", wb_data, reg_write_data);
                    errors++;
                end
            end
            if (reg_write_valid) begin
                rf[reg_write_addr] = reg_write_data;
            end
            wb_v = 1'b0;

            exp_done = (empty_edge >= 0) && (cyc >= empty_edge + 3);
            if (done !== exp_done) begin
                $display("Error: done expected %h got %h", exp_done, done);
                errors++;
            end
            stall_exp = (add_en && free_tag(1'b0) == '0) || (mul_en && free_tag(1'b1) == '0);
            if (a_stall !== stall_exp) begin
                $display("Error: a_stall expected %h got %h", stall_exp, a_stall);
                errors++;
            end

            // Dispatch pulses and unit launch
            for (int t = 1; t < NUM_TAGS; t++) begin
                read_start(t, s, sa, sb, so);
                exp_s = m_busy[t] && !m_started[t] && m_wj[t] == '0 && m_wk[t] == '0
                        && cyc == m_rdy[t] + 2;
                if (s !== exp_s) begin
                    $display("Error: start of tag %0d expected %h got %h", t, exp_s, s);
                    errors++;
                end else if (s) begin
                    if (sa !== exp_a[t]) begin
                        $display("Error: src_a of tag %0d expected %h got %h", t, exp_a[t], sa);
                        errors++;
                    end
                    if (sb !== exp_b[t]) begin
                        $display("Error: src_b of tag %0d expected %h got %h", t, exp_b[t], sb);
                        errors++;
                    end
                    if (so !== exp_op[t]) begin
                        $display("Error: op of tag %0d expected %h got %h", t, exp_op[t], so);
                        errors++;
                    end
                    m_started[t] = 1'b1;
                    u_pend[t]    = 1'b1;
                    u_delay[t]   = delay_tab[dly_idx % 256];
                    dly_idx++;
                    if (t >= int'(MUL_BASE_TAG)) begin
                        u_res[t] = sa * sb;
                    end else begin
                        u_res[t] = so ? sa + sb : sa - sb;
                    end
                end
            end

            // Issue lookup sees the status before this edge
            take     = (add_en || mul_en) && (rs != '0 || rt != '0 || rd != '0) && !stall_exp;
            is_mul_i = !add_en;
            slot     = free_tag(is_mul_i);
            wj       = ref_status[rs];
            wk       = imminstr ? '0 : ref_status[rt];
            if (cdb_valid && wj == cdb_tag) begin
                wj = '0;
            end
            if (cdb_valid && wk == cdb_tag) begin
                wk = '0;
            end

            if (cdb_valid) begin
                owner = latest_owner(cdb_tag);
                if (owner >= 0) begin
                    wb_v    = 1'b1;
                    wb_addr = reg_addr_t'(owner);
                    wb_data = exp_r[cdb_tag];
                end
                for (int i = 0; i < NUM_REGS; i++) begin
                    if (ref_status[i] == cdb_tag) begin
                        ref_status[i] = '0;
                    end
                end
                for (int u = 1; u < NUM_TAGS; u++) begin
                    waiting = m_wj[u] != '0 || m_wk[u] != '0;
                    if (m_wj[u] == cdb_tag) begin
                        m_wj[u] = '0;
                    end
                    if (m_wk[u] == cdb_tag) begin
                        m_wk[u] = '0;
                    end
                    if (m_busy[u] && waiting && m_wj[u] == '0 && m_wk[u] == '0) begin
                        m_rdy[u] = cyc;
                    end
                end
                m_busy[cdb_tag] = 1'b0;
            end

            // The source holds its instruction while the DUT stalls
            accepted = (add_en || mul_en) && !a_stall;
            if (take) begin
                predict(is_mul_i, op_flag, imminstr, rs, rt, rd, ext_imm, a, b, r);
                m_busy[slot]    = 1'b1;
                m_started[slot] = 1'b0;
                m_wj[slot]      = wj;
                m_wk[slot]      = wk;
                m_rdy[slot]     = cyc;
                exp_a[slot]     = a;
                exp_b[slot]     = b;
                exp_r[slot]     = r;
                exp_op[slot]    = op_flag;
                ref_status[rd]  = slot;
            end

            if (!model_idle()) begin
                was_busy = 1'b1;
            end else if (was_busy && empty_edge < 0) begin
                empty_edge = cyc;
            end

            // One broadcast per cycle with the lowest tag winning
            bc_v = 1'b0;
            for (int t = NUM_TAGS - 1; t >= 1; t--) begin
                if (u_pend[t] && u_delay[t] > 0) begin
                    u_delay[t]--;
                end
                if (u_pend[t] && u_delay[t] == 0) begin
                    bc_v = 1'b1;
                    bc_t = tag_t'(t);
                    bc_d = u_res[t];
                end
            end
            if (bc_v) begin
                u_pend[bc_t] = 1'b0;
            end
        end
    end

    task automatic finish_run();
        $display("Check errors: %0d, sequence errors: %0d", errors, flow_errors);
        if (errors == 0 && flow_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic report_timeout(input string msg);
        $display("%s", msg);
        flow_errors++;
    endtask

    task automatic tick();
        @(negedge clk);
        cdb_valid  = bc_v;
        cdb_tag    = bc_v ? bc_t : '0;
        cdb_data   = bc_v ? bc_d : '0;
        read_data1 = rf_read(rs);
        read_data2 = rf_read(rt);
    endtask

    task automatic set_instr(input logic is_mul, input logic op, input logic imm,
                             input reg_addr_t s1, input reg_addr_t s2,
                             input reg_addr_t dst, input word_t imm_val);
        add_en     = !is_mul;
        mul_en     = is_mul;
        op_flag    = op;
        imminstr   = imm;
        rs         = s1;
        rt         = s2;
        rd         = dst;
        ext_imm    = imm_val;
        read_data1 = rf_read(s1);
        read_data2 = rf_read(s2);
    endtask

    task automatic set_idle();
        add_en   = 1'b0;
        mul_en   = 1'b0;
        op_flag  = 1'b0;
        imminstr = 1'b0;
        rs       = '0;
        rt       = '0;
        rd       = '0;
    endtask

    // Holds the instruction until it is accepted
    task automatic issue_op(input logic is_mul, input logic op, input logic imm,
                            input reg_addr_t s1, input reg_addr_t s2,
                            input reg_addr_t dst, input word_t imm_val);
        int n;
        n = 0;
        set_instr(is_mul, op, imm, s1, s2, dst, imm_val);
        tick();
        while (!accepted && n < 100) begin
            tick();
            n++;
        end
        if (!accepted) begin
            report_timeout("Timeout waiting for an instruction to be accepted");
        end
        set_idle();
    endtask

    task automatic try_issue(input logic is_mul, input logic op, input reg_addr_t s1,
                             input reg_addr_t s2, input reg_addr_t dst, output logic ok);
        set_instr(is_mul, op, 1'b0, s1, s2, dst, '0);
        tick();
        ok = accepted;
        set_idle();
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (!model_idle() && n < 200) begin
            tick();
            n++;
        end
        if (!model_idle()) begin
            report_timeout("Timeout waiting for the stations to drain");
        end
    endtask

    task automatic wait_cdb(input tag_t t);
        int n;
        n = 0;
        tick();
        while (!(cdb_valid && cdb_tag == t) && n < 100) begin
            tick();
            n++;
        end
        if (!(cdb_valid && cdb_tag == t)) begin
            report_timeout("Timeout waiting for a broadcast on the CDB");
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (16) tick();
        reset = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        logic        ok;
        int          n;
        seed      = 32'hbcf6;
        reset     = 1'b1;
        ext_imm   = '0;
        cdb_valid = 1'b0;
        cdb_tag   = '0;
        cdb_data  = '0;
        set_idle();
        read_data1 = '0;
        read_data2 = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            init_vals[i] = $random(seed);
        end
        for (int i = 0; i < 256; i++) begin
            delay_tab[i] = 1 + int'($unsigned($random(seed)) % 4);
        end
        apply_reset();

        // Ready add and then an immediate difference
        r = $random(seed);
        issue_op(1'b0, 1'b1, 1'b0, 5'd2, 5'd3, 5'd1, '0);
        issue_op(1'b0, 1'b0, 1'b1, 5'd5, 5'd0, 5'd4, r);
        drain();

        // Multiply waits on the add result
        issue_op(1'b0, 1'b1, 1'b0, 5'd2, 5'd3, 5'd6, '0);
        issue_op(1'b1, 1'b0, 1'b0, 5'd6, 5'd4, 5'd7, '0);
        drain();

        // Issue lands in the cycle its source is broadcast
        issue_op(1'b0, 1'b1, 1'b0, 5'd1, 5'd2, 5'd8, '0);
        wait_cdb(ADD_BASE_TAG);
        issue_op(1'b1, 1'b0, 1'b0, 5'd8, 5'd3, 5'd9, '0);
        drain();

        // r9 renamed twice so the first result is not written
        issue_op(1'b0, 1'b1, 1'b0, 5'd1, 5'd2, 5'd9, '0);
        issue_op(1'b0, 1'b0, 1'b0, 5'd3, 5'd4, 5'd9, '0);
        drain();

        // Three adds wait on a multiply and a fourth stalls
        r = $random(seed);
        issue_op(1'b1, 1'b0, 1'b0, 5'd1, 5'd2, 5'd10, '0);
        issue_op(1'b0, 1'b1, 1'b0, 5'd10, 5'd3, 5'd11, '0);
        issue_op(1'b0, 1'b1, 1'b0, 5'd10, 5'd4, 5'd12, '0);
        issue_op(1'b0, 1'b0, 1'b1, 5'd10, 5'd0, 5'd13, r);
        try_issue(1'b0, 1'b1, 5'd1, 5'd2, 5'd14, ok);
        if (ok) begin
            $display("A fourth add was accepted while the adder bank was full");
            flow_errors++;
        end
        try_issue(1'b1, 1'b0, 5'd5, 5'd6, 5'd15, ok);
        if (!ok) begin
            $display("A multiply was refused during an adder stall");
            flow_errors++;
        end
        issue_op(1'b0, 1'b1, 1'b0, 5'd1, 5'd2, 5'd14, '0);
        drain();

        // Random program from a fresh reset
        apply_reset();
        for (int k = 0; k < 40; k++) begin
            r = $random(seed);
            issue_op(r[1:0] == 2'd0, r[2], r[5:3] == 3'd0, reg_addr_t'(r[8:6]),
                     reg_addr_t'(r[11:9]), reg_addr_t'(1 + r[14:12] % 7), $random(seed));
        end
        if (done) begin
            $display("done was high before the program finished");
            flow_errors++;
        end
        drain();
        n = 0;
        while (!done && n < 20) begin
            tick();
            n++;
        end
        if (!done) begin
            report_timeout("Timeout waiting for done");
        end
        repeat (5) tick();
        finish_run();
    end

endmodule

//--- tb.f
+incdir+testbench
rtl/rs_pkg.sv
rtl/register_status.sv
rtl/station_bank.sv
rtl/issue_control.sv
rtl/tomasulo_rs.sv
testbench/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
